//--- build.f
+incdir+.
cpuPkg.sv
microSequencer.sv
controlUnit.sv
instructionLatch.sv
aluExec.sv
datapath.sv
memoryPort.sv
multicycleCore.sv
multicycleCore_props.sv
tb_multicycleCore.sv

//--- Makefile
# Verilator build for the multicycle RV32I core.
VERILATOR ?= verilator
TOP       ?= tb_multicycleCore
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_multicycleCore.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_multicycleCore;

    localparam int numTests   = 18;
    localparam int cycleLimit = numTests * 8 * 5 + 50;
    localparam int addrBits   = $clog2(`MEM_WORDS);

    localparam logic [6:0]  opcReg    = 7'b0110011;
    localparam logic [6:0]  opcImm    = 7'b0010011;
    localparam logic [6:0]  opcLoad   = 7'b0000011;
    localparam logic [6:0]  opcStore  = 7'b0100011;
    localparam logic [6:0]  opcBranch = 7'b1100011;
    localparam logic [6:0]  opcJal    = 7'b1101111;
    localparam logic [6:0]  opcJalr   = 7'b1100111;
    localparam logic [31:0] ecallWord = 32'h0000_0073;

    typedef struct packed {
        logic [7:0][31:0] prog;
        logic [31:0]      addr;    // address of the final store.
        logic [31:0]      value;
        logic [7:0]       writes;  // stores the program makes in all.
    } testEntry_t;

    logic        clk;
    logic        reset;
    logic [31:0] memAddr;
    logic [31:0] memWData;
    logic [31:0] memRData;
    logic        memRead;
    logic        memWrite;
    logic        halted;

    logic [31:0]      mem [0:`MEM_WORDS-1];
    logic [7:0][31:0] curProg;
    logic [31:0]      writeAddrs [$];
    logic [31:0]      writeData [$];
    logic             writeWhileHalted;
    testEntry_t       tests [numTests];
    string            names [numTests];
    int               testCount;
    int               errors;
    int               passCount;
    int               failCount;
    int               cycleCount = 0;

    multicycleCore dut (
        .clk      (clk),
        .reset    (reset),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memRData (memRData),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted)
    );

    always #4 clk = ~clk;

    // ####################
    // memory model reloaded from curProg while reset is held.
    // a read without memRead returns zero.
    assign memRData = memRead ? mem[memAddr[addrBits+1:2]] : 32'h0;

    always @(posedge clk) begin : memModel
        int i;
        if (!reset) begin
            for (i = 0; i < `MEM_WORDS; i++) mem[i] <= 32'h0;
            for (i = 0; i < 8; i++) mem[i] <= curProg[i];
            writeAddrs.delete();
            writeData.delete();
            writeWhileHalted <= 1'b0;
        end else if (memWrite) begin
            mem[memAddr[addrBits+1:2]] <= memWData;
            writeAddrs.push_back(memAddr);
            writeData.push_back(memWData);
            if (halted) writeWhileHalted <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ####################
    // instruction encoding and expected results.
    function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opcReg};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] storeWord(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcStore};
    endfunction

    function automatic logic [31:0] branchWord(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
    endfunction

    function automatic logic [31:0] jalWord(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
    endfunction

    function automatic logic [31:0] signExtend12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // op index order is add, sub, and, or, xor, slt.
    function automatic logic [2:0] funct3For(input int op);
        case (op)
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b100;
            5:       return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [31:0] expectedAlu(input int op, input logic [31:0] a,
                                                input logic [31:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic addTest(input string name, input testEntry_t entry);
        tests[testCount] = entry;
        names[testCount] = name;
        testCount++;
    endtask

    task automatic buildTests();
        testEntry_t  entry;
        logic [11:0] immA;
        logic [11:0] immB;
        logic [11:0] addr;
        logic [2:0]  f3;
        int          k;
        int          op;
        string       rNames [6];
        string       iNames [5];
        int          iOps [5];
        rNames = '{"add", "sub", "and", "or", "xor", "slt"};
        iNames = '{"addi", "andi", "ori", "xori", "slti"};
        iOps   = '{0, 2, 3, 4, 5};
        for (k = 0; k < 6; k++) begin
            immA  = 12'($urandom);
            immB  = 12'($urandom);
            addr  = 12'(32'h100 + testCount * 4);
            entry = '0;
            entry.prog[0] = iTypeWord(immA, 5'd0, 3'b000, 5'd1, opcImm);
            entry.prog[1] = iTypeWord(immB, 5'd0, 3'b000, 5'd2, opcImm);
            entry.prog[2] = rTypeWord((k == 1) ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1,
                                      funct3For(k), 5'd3);
            entry.prog[3] = storeWord(addr, 5'd3, 5'd0);
            entry.prog[4] = ecallWord;
            entry.addr    = {20'd0, addr};
            entry.value   = expectedAlu(k, signExtend12(immA), signExtend12(immB));
            entry.writes  = 8'd1;
            addTest({"r-type ", rNames[k]}, entry);
        end
        for (k = 0; k < 5; k++) begin
            op    = iOps[k];
            immA  = 12'($urandom);
            immB  = 12'($urandom);
            addr  = 12'(32'h100 + testCount * 4);
            entry = '0;
            entry.prog[0] = iTypeWord(immA, 5'd0, 3'b000, 5'd1, opcImm);
            entry.prog[1] = iTypeWord(immB, 5'd1, funct3For(op), 5'd3, opcImm);
            entry.prog[2] = storeWord(addr, 5'd3, 5'd0);
            entry.prog[3] = ecallWord;
            entry.addr    = {20'd0, addr};
            entry.value   = expectedAlu(op, signExtend12(immA), signExtend12(immB));
            entry.writes  = 8'd1;
            addTest({"i-type ", iNames[k]}, entry);
        end
        // store, load back from a scratch word, add one.
        immA  = 12'($urandom);
        addr  = 12'(32'h100 + testCount * 4);
        entry = '0;
        entry.prog[0] = iTypeWord(immA, 5'd0, 3'b000, 5'd1, opcImm);
        entry.prog[1] = storeWord(12'h3f0, 5'd1, 5'd0);
        entry.prog[2] = iTypeWord(12'h3f0, 5'd0, 3'b010, 5'd2, opcLoad);
        entry.prog[3] = iTypeWord(12'd1, 5'd2, 3'b000, 5'd3, opcImm);
        entry.prog[4] = storeWord(addr, 5'd3, 5'd0);
        entry.prog[5] = ecallWord;
        entry.addr    = {20'd0, addr};
        entry.value   = signExtend12(immA) + 32'd1;
        entry.writes  = 8'd2;
        addTest("load and store", entry);
        // beq taken, beq not taken, bne taken, bne not taken.
        for (k = 0; k < 4; k++) begin
            f3    = (k >= 2) ? 3'b001 : 3'b000;
            immA  = 12'($urandom);
            immB  = (k == 0 || k == 3) ? immA : immA ^ 12'h001;
            addr  = 12'(32'h100 + testCount * 4);
            entry = '0;
            entry.prog[0] = iTypeWord(immA, 5'd0, 3'b000, 5'd1, opcImm);
            entry.prog[1] = iTypeWord(immB, 5'd0, 3'b000, 5'd2, opcImm);
            entry.prog[2] = branchWord(13'd8, 5'd2, 5'd1, f3);
            entry.prog[3] = iTypeWord(12'd1, 5'd1, 3'b000, 5'd1, opcImm);  // skipped if taken.
            entry.prog[4] = storeWord(addr, 5'd1, 5'd0);
            entry.prog[5] = ecallWord;
            entry.addr    = {20'd0, addr};
            entry.value   = signExtend12(immA) + ((k == 0 || k == 2) ? 32'd0 : 32'd1);
            entry.writes  = 8'd1;
            addTest((k == 0) ? "beq taken" : (k == 1) ? "beq not taken" :
                    (k == 2) ? "bne taken" : "bne not taken", entry);
        end
        // jal sits at address 4 so the link is 8.
        immA  = 12'($urandom);
        addr  = 12'(32'h100 + testCount * 4);
        entry = '0;
        entry.prog[0] = iTypeWord(immA, 5'd0, 3'b000, 5'd4, opcImm);
        entry.prog[1] = jalWord(21'd8, 5'd1);
        entry.prog[2] = iTypeWord(immA, 5'd0, 3'b000, 5'd1, opcImm);
        entry.prog[3] = storeWord(addr, 5'd1, 5'd0);
        entry.prog[4] = ecallWord;
        entry.addr    = {20'd0, addr};
        entry.value   = 32'd8;
        entry.writes  = 8'd1;
        addTest("jal link", entry);
        // jalr at address 4 jumps to x2 + 1 which is 12.
        addr  = 12'(32'h100 + testCount * 4);
        entry = '0;
        entry.prog[0] = iTypeWord(12'd11, 5'd0, 3'b000, 5'd2, opcImm);
        entry.prog[1] = iTypeWord(12'd1, 5'd2, 3'b000, 5'd1, opcJalr);
        entry.prog[2] = iTypeWord(immA, 5'd0, 3'b000, 5'd1, opcImm);
        entry.prog[3] = storeWord(addr, 5'd1, 5'd0);
        entry.prog[4] = ecallWord;
        entry.addr    = {20'd0, addr};
        entry.value   = 32'd8;
        entry.writes  = 8'd1;
        addTest("jalr link", entry);
    endtask

    // ####################
    // running and checking.
    task automatic reportError(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic runTest(input int t);
        int errBefore;
        errBefore = errors;
        @(posedge clk);
        reset   <= 1'b0;
        curProg <= tests[t].prog;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        while (!halted) @(negedge clk);
        repeat (4) @(negedge clk);  // the core should stay parked.
        assert (halted)
            else reportError($sformatf("%s: halted fell before reset", names[t]));
        assert (!writeWhileHalted)
            else reportError($sformatf("%s: memory written while halted", names[t]));
        assert (writeAddrs.size() == int'(tests[t].writes))
            else reportError($sformatf("%s: %0d writes, expected %0d", names[t],
                                       writeAddrs.size(), tests[t].writes));
        if (writeAddrs.size() > 0) begin
            assert (writeAddrs[$] == tests[t].addr)
                else reportError($sformatf("%s: store address %h, expected %h", names[t],
                                           writeAddrs[$], tests[t].addr));
            assert (writeData[$] == tests[t].value)
                else reportError($sformatf("%s: stored %h, expected %h", names[t],
                                           writeData[$], tests[t].value));
        end
        if (errors == errBefore) begin
            passCount++;
            $display("test %0d %s: pass", t, names[t]);
        end else begin
            failCount++;
            $display("test %0d %s: fail", t, names[t]);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b0;
        curProg   = '0;
        testCount = 0;
        errors    = 0;
        passCount = 0;
        failCount = 0;
        void'($urandom(79));  // seed once.
        buildTests();
        for (int t = 0; t < testCount; t++) begin
            runTest(t);
        end
        $display("%0d tests run, %0d passed, %0d failed", testCount, passCount, failCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- multicycleCore_props.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module multicycleCore_props (
    input logic        clk,
    input logic        reset,
    input logic [31:0] memAddr,
    input logic        memRead,
    input logic        memWrite,
    input logic        halted
);

    // one shared port, a cycle either reads or writes.
    readWriteExclusive: assert property (@(posedge clk) !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    noWriteHalted: assert property (@(posedge clk) halted |-> !memWrite)
        else $error("memory write while the core is halted");

    // only reset leaves halt.
    haltHolds: assert property (@(posedge clk) (halted && reset) |=> halted)
        else $error("halted dropped without a reset");

    writeInRange: assert property (@(posedge clk)
        memWrite |-> (memAddr[1:0] == 2'b00 && memAddr < 32'(`MEM_WORDS * 4)))
        else $error("memory write to an unaligned or out-of-range address");

endmodule

bind multicycleCore multicycleCore_props props (
    .clk      (clk),
    .reset    (reset),
    .memAddr  (memAddr),
    .memRead  (memRead),
    .memWrite (memWrite),
    .halted   (halted)
);

//--- multicycleCore.sv
`timescale 1ns/1ps

module multicycleCore import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] memAddr,
    output logic [31:0] memWData,
    input  logic [31:0] memRData,
    output logic        memRead,
    output logic        memWrite,
    output logic        halted
);

    ctrlWord_t     ctrl;
    decodedInstr_t instr;
    logic [31:0]   memData;
    logic [31:0]   pc;
    logic [31:0]   aluOut;
    logic [31:0]   regB;

    controlUnit control (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .ctrl   (ctrl),
        .halted (halted)
    );

    instructionLatch latchIn (
        .clk      (clk),
        .reset    (reset),
        .memRData (memRData),
        .ctrl     (ctrl),
        .instr    (instr),
        .memData  (memData)
    );

    datapath dp (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .instr   (instr),
        .memData (memData),
        .pc      (pc),
        .aluOut  (aluOut),
        .regB    (regB)
    );

    memoryPort port (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .pc       (pc),
        .aluOut   (aluOut),
        .regB     (regB),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memRead  (memRead),
        .memWrite (memWrite)
    );

endmodule

//--- memoryPort.sv
`timescale 1ns/1ps

module memoryPort import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  ctrlWord_t   ctrl,
    input  logic [31:0] pc,
    input  logic [31:0] aluOut,
    input  logic [31:0] regB,
    output logic [31:0] memAddr,
    output logic [31:0] memWData,
    output logic        memRead,
    output logic        memWrite
);

    logic [31:0] storeData;

    // store data is staged during exStore, regB is stable from decode on.
    always_ff @(posedge clk) begin
        storeData <= regB;
    end

    assign memAddr  = ctrl.iOrD ? aluOut : pc;
    assign memWData = storeData;
    assign memRead  = ctrl.memRead & reset;   // quiet while reset is held.
    assign memWrite = ctrl.memWrite & reset;

endmodule

//--- datapath.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapath import cpuPkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  ctrlWord_t     ctrl,
    input  decodedInstr_t instr,
    input  logic [31:0]   memData,
    output logic [31:0]   pc,
    output logic [31:0]   aluOut,
    output logic [31:0]   regB
);

    logic [31:0] regFile [0:`REG_COUNT-1];
    logic [31:0] regA;
    logic [31:0] srcAVal;
    logic [31:0] srcBVal;
    logic [31:0] aluResult;
    logic [31:0] wbData;
    logic [31:0] pcPlus4;
    logic [31:0] nextPc;
    logic        zero;
    logic        branchTaken;

    // ####################
    // operand selection and ALU.
    assign srcAVal = ctrl.srcA ? regA : pc;

    always_comb begin
        case (ctrl.srcB)
            srcBFour: srcBVal = 32'd4;
            srcBImm:  srcBVal = instr.imm;
            default:  srcBVal = regB;
        endcase
    end

    aluExec alu (
        .a        (srcAVal),
        .b        (srcBVal),
        .aluOp    (ctrl.aluOp),
        .funct3   (instr.funct3),
        .funct7b5 (instr.funct7b5),
        .isRType  (instr.opcode == opR),
        .result   (aluResult),
        .zero     (zero)
    );

    // operand and result registers follow every cycle.
    always_ff @(posedge clk) begin
        regA   <= (instr.rs1 == 5'd0) ? 32'd0 : regFile[instr.rs1];
        regB   <= (instr.rs2 == 5'd0) ? 32'd0 : regFile[instr.rs2];
        aluOut <= aluResult;
    end

    // ####################
    // write back.
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.wbSel)
            wbMem:   wbData = memData;
            wbPc4:   wbData = pcPlus4;
            default: wbData = aluOut;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.regWrite && instr.rd != 5'd0) begin
            regFile[instr.rd] <= wbData;
        end
    end

    // ####################
    // next PC, beq on zero, bne on nonzero.
    assign branchTaken = ctrl.pcWriteCond & (zero ^ instr.funct3[0]);
    assign nextPc      = ctrl.pcSel ? aluOut : {aluResult[31:1], 1'b0};  // jalr clears bit 0.

    always_ff @(posedge clk) begin
        if (!reset) begin
            pc <= `RESET_PC;
        end else if (ctrl.pcWrite || branchTaken) begin
            pc <= nextPc;
        end else if (ctrl.pcWriteCond) begin
            pc <= pcPlus4;  // branch falls through.
        end
    end

endmodule

//--- aluExec.sv
`timescale 1ns/1ps

module aluExec import cpuPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  aluOp_t      aluOp,
    input  logic [2:0]  funct3,
    input  logic        funct7b5,
    input  logic        isRType,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (aluOp)
            aluAdd:    result = a + b;
            aluBranch: result = a - b;
            default: begin
                case (funct3)
                    3'b000: begin
                        // funct7 bit only counts for R-type, addi carries imm bits there.
                        if (isRType && funct7b5) begin
                            result = a - b;
                        end else begin
                            result = a + b;
                        end
                    end
                    3'b010:  result = {31'd0, $signed(a) < $signed(b)};
                    3'b100:  result = a ^ b;
                    3'b110:  result = a | b;
                    3'b111:  result = a & b;
                    default: result = a + b;
                endcase
            end
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

//--- instructionLatch.sv
`timescale 1ns/1ps

module instructionLatch import cpuPkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   memRData,
    input  ctrlWord_t     ctrl,
    output decodedInstr_t instr,
    output logic [31:0]   memData
);

    logic [31:0] ir;

    always_ff @(posedge clk) begin
        if (!reset) begin
            ir <= 32'h0000_0013;  // addi x0, x0, 0.
        end else if (ctrl.irWrite) begin
            ir <= memRData;
        end
    end

    always_ff @(posedge clk) begin
        memData <= memRData;
    end

    always_comb begin
        instr.opcode   = opcode_t'(ir[6:0]);
        instr.rd       = ir[11:7];
        instr.funct3   = ir[14:12];
        instr.rs1      = ir[19:15];
        instr.rs2      = ir[24:20];
        instr.funct7b5 = ir[30];
        case (instr.opcode)
            opStore:  instr.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            opBranch: instr.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            opJal:    instr.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:  instr.imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

endmodule

//--- controlUnit.sv
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  decodedInstr_t instr,
    output ctrlWord_t     ctrl,
    output logic          halted
);

    cpuState_t state;
    cpuState_t nextState;

    microSequencer sequencer (
        .state     (state),
        .opcode    (instr.opcode),
        .nextState (nextState)
    );

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= fetch;
        end else begin
            state <= nextState;
        end
    end

    assign halted = (state == halt);

    // ####################
    // one control word per state.
    always_comb begin
        ctrl = '0;
        case (state)
            fetch: begin
                ctrl.memRead = 1'b1;
                ctrl.irWrite = 1'b1;
            end
            decode: begin
                ctrl.srcB = srcBImm;  // branch or jal target into the result register.
            end
            exR: begin
                ctrl.srcA  = 1'b1;
                ctrl.aluOp = aluFunct;
            end
            exI: begin
                ctrl.srcA  = 1'b1;
                ctrl.srcB  = srcBImm;
                ctrl.aluOp = aluFunct;
            end
            exLoad, exStore: begin
                ctrl.srcA = 1'b1;
                ctrl.srcB = srcBImm;
            end
            exBranch: begin
                ctrl.pcWriteCond = 1'b1;
                ctrl.pcSel       = 1'b1;
                ctrl.srcA        = 1'b1;
                ctrl.aluOp       = aluBranch;
            end
            exJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = wbPc4;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSel    = 1'b1;
            end
            exJalr: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = wbPc4;
                ctrl.pcWrite  = 1'b1;
                ctrl.srcA     = 1'b1;
                ctrl.srcB     = srcBImm;
            end
            memLoad: begin
                ctrl.iOrD    = 1'b1;
                ctrl.memRead = 1'b1;
            end
            memStore: begin
                ctrl.iOrD     = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.pcWrite  = 1'b1;
                ctrl.srcB     = srcBFour;
            end
            wbAlu, wbLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = (state == wbLoad) ? wbMem : wbAluRes;
                ctrl.pcWrite  = 1'b1;
                ctrl.srcB     = srcBFour;  // pc + 4 through the ALU.
            end
            default: ctrl = '0;  // halt keeps everything quiet.
        endcase
    end

endmodule

//--- microSequencer.sv
`timescale 1ns/1ps

module microSequencer import cpuPkg::*; (
    input  cpuState_t state,
    input  opcode_t   opcode,
    output cpuState_t nextState
);

    always_comb begin
        nextState = halt;
        case (state)
            fetch: nextState = decode;

            // dispatch on the latched opcode.
            decode: begin
                case (opcode)
                    opR:      nextState = exR;
                    opI:      nextState = exI;
                    opLoad:   nextState = exLoad;
                    opStore:  nextState = exStore;
                    opBranch: nextState = exBranch;
                    opJal:    nextState = exJal;
                    opJalr:   nextState = exJalr;
                    default:  nextState = halt;  // ecall and anything unknown.
                endcase
            end

            exR, exI: nextState = wbAlu;
            exLoad:   nextState = memLoad;
            memLoad:  nextState = wbLoad;
            exStore:  nextState = memStore;

            // these finish the instruction.
            exBranch, exJal, exJalr: nextState = fetch;
            memStore, wbAlu, wbLoad: nextState = fetch;

            halt:    nextState = halt;
            default: nextState = halt;
        endcase
    end

endmodule

//--- cpuPkg.sv
package cpuPkg;

    // ####################
    // instruction state machine.
    typedef enum logic [3:0] {
        fetch    = 4'd0,
        decode   = 4'd1,
        exR      = 4'd2,
        exI      = 4'd3,
        exLoad   = 4'd4,
        exStore  = 4'd5,
        exBranch = 4'd6,
        exJal    = 4'd7,
        exJalr   = 4'd8,
        memLoad  = 4'd9,
        memStore = 4'd10,
        wbAlu    = 4'd11,
        wbLoad   = 4'd12,
        halt     = 4'd13
    } cpuState_t;

    // RV32I major opcodes that the core knows.
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opI      = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opSystem = 7'b1110011
    } opcode_t;

    typedef enum logic [1:0] {
        aluAdd    = 2'd0,
        aluBranch = 2'd1,  // subtract, zero flag feeds the branch.
        aluFunct  = 2'd2
    } aluOp_t;

    typedef enum logic [1:0] {
        wbAluRes = 2'd0,
        wbMem    = 2'd1,
        wbPc4    = 2'd2
    } wbSel_t;

    typedef enum logic [1:0] {
        srcBReg  = 2'd0,
        srcBFour = 2'd1,
        srcBImm  = 2'd2
    } srcB_t;

    // ####################
    // control word and decoded instruction.
    typedef struct packed {
        logic   pcWrite;
        logic   pcWriteCond;
        logic   iOrD;      // set to address memory from the ALU result register.
        logic   memRead;
        logic   memWrite;
        logic   irWrite;
        logic   regWrite;
        wbSel_t wbSel;
        logic   pcSel;     // set to take the ALU result register.
        aluOp_t aluOp;
        logic   srcA;      // set for register A, clear for PC.
        srcB_t  srcB;
    } ctrlWord_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic        funct7b5;
        logic [31:0] imm;
    } decodedInstr_t;

endpackage

//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// address of the first fetch after reset.
`define RESET_PC  32'h0000_0000

// architectural integer registers, x0 included.
`define REG_COUNT 32

// word depth of the test memory model.
`define MEM_WORDS 256

`endif
